/* bus_master/read_engine.sv */
`timescale 1ns/1ns
module read_engine (
	input  logic                  clock,
	input  logic                  reset,
	input  lsu_pkg::access_plan_t held,
	input  logic                  start,
	output logic                  arvalid,
	output lsu_pkg::addr_t        araddr,
	output lsu_pkg::xfer_size_t   arsize,
	input  logic                  arready,
	output logic                  rready,
	input  logic                  rvalid,
	input  lsu_pkg::bus_data_t    rdata,
	output logic                  finish,
	output lsu_pkg::word_t        load_data
);
	import lsu_pkg::*;

	typedef enum logic [2:0] {
		R_IDLE,
		R_ADDR,
		R_RESP,
		R_ADDR2,
		R_RESP2
	} read_state_t;

	read_state_t state;
	read_state_t state_next;
	bus_data_t   first_beat;
	bus_data_t   first_src;
	word_t       merged;
	word_t       extended;
	logic        last_r;

	// ------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------
	always_comb begin
		state_next = state;
		case (state)
			// no restart while the finished request is still held
			R_IDLE:  if (start && !finish) state_next = R_ADDR;
			R_ADDR:  if (arready) state_next = R_RESP;
			R_RESP:  if (rvalid) state_next = held.split ? R_ADDR2 : R_IDLE;
			R_ADDR2: if (arready) state_next = R_RESP2;
			R_RESP2: if (rvalid) state_next = R_IDLE;
			default: state_next = R_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= R_IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign arvalid = (state == R_ADDR) || (state == R_ADDR2);
	assign rready  = (state == R_RESP) || (state == R_RESP2);
	assign araddr  = (state == R_ADDR2) ? held.second_addr : held.first_addr;
	assign arsize  = held.size;

	assign last_r = rvalid && (((state == R_RESP) && !held.split) || (state == R_RESP2));

	always_ff @(posedge clock) begin
		if (reset) begin
			finish <= 1'b0;
		end else begin
			finish <= last_r;
		end
	end

	// ------------------------------------------------------------
	// byte merge and extension
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (state == R_RESP && rvalid && held.split) begin
			first_beat <= rdata;
		end
	end

	assign first_src = held.split ? first_beat : rdata;

	// bytes past the top lane wrap into the second beat
	always_comb begin
		logic [LANE_BITS:0] idx;
		for (int i = 0; i < 4; i++) begin
			idx = {1'b0, held.lane} + (LANE_BITS + 1)'(i);
			if (idx[LANE_BITS]) begin
				merged[8*i +: 8] = rdata[8 * idx[LANE_BITS-1:0] +: 8];
			end else begin
				merged[8*i +: 8] = first_src[8 * idx[LANE_BITS-1:0] +: 8];
			end
		end
	end

	always_comb begin
		case (held.kind)
			LD_B:    extended = {{24{merged[7]}}, merged[7:0]};
			LD_BU:   extended = {24'b0, merged[7:0]};
			LD_H:    extended = {{16{merged[15]}}, merged[15:0]};
			LD_HU:   extended = {16'b0, merged[15:0]};
			default: extended = merged;
		endcase
	end

	always_ff @(posedge clock) begin
		if (last_r) begin
			load_data <= extended;
		end
	end

	// the AR request stays put until it is taken
	assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arsize))
		else $error("AR request dropped or changed before arready");

endmodule

/* bus_master/write_engine.sv */
`timescale 1ns/1ns
module write_engine (
	input  logic                  clock,
	input  logic                  reset,
	input  lsu_pkg::access_plan_t held,
	input  logic                  start,
	output logic                  awvalid,
	output lsu_pkg::addr_t        awaddr,
	output lsu_pkg::xfer_size_t   awsize,
	input  logic                  awready,
	output logic                  wvalid,
	output lsu_pkg::bus_data_t    wdata,
	output lsu_pkg::strb_t        wstrb,
	input  logic                  wready,
	output logic                  bready,
	input  logic                  bvalid,
	output logic                  finish
);
	import lsu_pkg::*;

	typedef enum logic [2:0] {
		W_IDLE,
		W_REQ,
		W_RESP,
		W_REQ2,
		W_RESP2
	} write_state_t;

	write_state_t state;
	write_state_t state_next;
	logic         req_done;
	logic         launch;
	logic         second;

	// both address and data accepted, or accepted this cycle
	assign req_done = !(awvalid && !awready) && !(wvalid && !wready);

	always_comb begin
		state_next = state;
		case (state)
			W_IDLE:  if (start && !finish) state_next = W_REQ;
			W_REQ:   if (req_done) state_next = W_RESP;
			W_RESP:  if (bvalid) state_next = held.split ? W_REQ2 : W_IDLE;
			W_REQ2:  if (req_done) state_next = W_RESP2;
			W_RESP2: if (bvalid) state_next = W_IDLE;
			default: state_next = W_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= W_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// ------------------------------------------------------------
	// address and data valid flags
	// ------------------------------------------------------------
	assign launch = (state_next == W_REQ && state == W_IDLE) ||
		(state_next == W_REQ2 && state == W_RESP);

	always_ff @(posedge clock) begin
		if (reset) begin
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
		end else if (launch) begin
			awvalid <= 1'b1;
			wvalid  <= 1'b1;
		end else begin
			if (awready) begin
				awvalid <= 1'b0;
			end
			if (wready) begin
				wvalid <= 1'b0;
			end
		end
	end

	assign bready = (state == W_RESP) || (state == W_RESP2);

	always_ff @(posedge clock) begin
		if (reset) begin
			finish <= 1'b0;
		end else begin
			finish <= bvalid && (((state == W_RESP) && !held.split) || (state == W_RESP2));
		end
	end

	// second transfer carries the spilled bytes from lane 0
	assign second = (state == W_REQ2) || (state == W_RESP2);
	assign awaddr = second ? held.second_addr : held.first_addr;
	assign wstrb  = second ? held.second_strb : held.first_strb;
	assign wdata  = held.store_beat;
	assign awsize = held.size;

	assert property (@(posedge clock) disable iff (reset)
		wvalid |-> wstrb != '0)
		else $error("write beat without strobes");

endmodule

/* common/lsu_pkg.sv */
package lsu_pkg;

	// ------------------------------------------------------------
	// bus geometry
	// ------------------------------------------------------------
	localparam int BEAT_BYTES = 8;
	localparam int LANE_BITS  = $clog2(BEAT_BYTES);

	typedef logic [31:0]             addr_t;
	typedef logic [31:0]             word_t;
	typedef logic [8*BEAT_BYTES-1:0] bus_data_t;
	typedef logic [BEAT_BYTES-1:0]   strb_t;
	typedef logic [LANE_BITS-1:0]    lane_t;
	typedef logic [4:0]              reg_idx_t;
	typedef logic [2:0]              xfer_size_t;

	// bus size codes
	localparam xfer_size_t SIZE_BYTE = 3'd0;
	localparam xfer_size_t SIZE_HALF = 3'd1;
	localparam xfer_size_t SIZE_WORD = 3'd2;

	// loads first, stores from ST_B upward
	typedef enum logic [2:0] {
		LD_B  = 3'd0,
		LD_H  = 3'd1,
		LD_W  = 3'd2,
		LD_BU = 3'd3,
		LD_HU = 3'd4,
		ST_B  = 3'd5,
		ST_H  = 3'd6,
		ST_W  = 3'd7
	} access_kind_t;

	// ------------------------------------------------------------
	// request and planned access
	// ------------------------------------------------------------
	typedef struct packed {
		access_kind_t kind;
		addr_t        addr;
		word_t        wdata;
		reg_idx_t     rd;
	} lsu_req_t;

	typedef struct packed {
		access_kind_t kind;
		reg_idx_t     rd;
		lane_t        lane;
		xfer_size_t   size;
		logic         split;
		addr_t        first_addr;
		addr_t        second_addr;
		strb_t        first_strb;
		strb_t        second_strb;
		bus_data_t    store_beat;
	} access_plan_t;

	function automatic logic is_store_kind(access_kind_t kind);
		return kind >= ST_B;
	endfunction

endpackage

/* hw/access_planner.sv */
`timescale 1ns/1ns
module access_planner (
	input  lsu_pkg::lsu_req_t     req,
	output lsu_pkg::access_plan_t plan
);
	import lsu_pkg::*;

	lane_t                  lane;
	strb_t                  base_strb;
	logic [2*BEAT_BYTES-1:0] span;
	addr_t                  aligned_addr;

	assign lane         = req.addr[LANE_BITS-1:0];
	assign aligned_addr = {req.addr[31:LANE_BITS], {LANE_BITS{1'b0}}};

	// bytes of the access as a mask at lane 0
	always_comb begin
		case (req.kind)
			LD_B, LD_BU, ST_B: base_strb = strb_t'(8'h01);
			LD_H, LD_HU, ST_H: base_strb = strb_t'(8'h03);
			default:           base_strb = strb_t'(8'h0f);
		endcase
	end

	// ------------------------------------------------------------
	// strobes over two beats
	// ------------------------------------------------------------
	// the upper half of the span is what spills into the next beat
	assign span = {{BEAT_BYTES{1'b0}}, base_strb} << lane;

	always_comb begin
		plan.kind        = req.kind;
		plan.rd          = req.rd;
		plan.lane        = lane;
		plan.first_addr  = req.addr;
		plan.second_addr = aligned_addr + addr_t'(BEAT_BYTES);
		plan.first_strb  = span[BEAT_BYTES-1:0];
		plan.second_strb = span[2*BEAT_BYTES-1:BEAT_BYTES];

		case (req.kind)
			LD_B, LD_BU, ST_B: plan.size = SIZE_BYTE;
			LD_H, LD_HU, ST_H: plan.size = SIZE_HALF;
			default:           plan.size = SIZE_WORD;
		endcase

		// word past lane 4 or half at lane 7 crosses the beat
		case (req.kind)
			LD_W, ST_W:        plan.split = lane > lane_t'(4);
			LD_H, LD_HU, ST_H: plan.split = lane == lane_t'(7);
			default:           plan.split = 1'b0;
		endcase
	end

	// ------------------------------------------------------------
	// store data rotated into its lanes
	// ------------------------------------------------------------
	// lane index wraps mod 8 so spilled bytes land from lane 0
	always_comb begin
		plan.store_beat = '0;
		for (int i = 0; i < 4; i++) begin
			plan.store_beat[8 * lane_t'(lane + lane_t'(i)) +: 8] = req.wdata[8*i +: 8];
		end
	end

endmodule

/* hw/lsu_top.sv */
`timescale 1ns/1ns
module lsu_top (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  req_valid,
	input  lsu_pkg::lsu_req_t     req,
	output logic                  allowin,
	output logic                  done,
	output logic                  wb_valid,
	output lsu_pkg::reg_idx_t     wb_rd,
	output lsu_pkg::word_t        wb_data,
	// read address and data
	output logic                  arvalid,
	output lsu_pkg::addr_t        araddr,
	output lsu_pkg::xfer_size_t   arsize,
	input  logic                  arready,
	output logic                  rready,
	input  logic                  rvalid,
	input  lsu_pkg::bus_data_t    rdata,
	// write address, data and response
	output logic                  awvalid,
	output lsu_pkg::addr_t        awaddr,
	output lsu_pkg::xfer_size_t   awsize,
	input  logic                  awready,
	output logic                  wvalid,
	output lsu_pkg::bus_data_t    wdata,
	output lsu_pkg::strb_t        wstrb,
	input  logic                  wready,
	output logic                  bready,
	input  logic                  bvalid
);
	import lsu_pkg::*;

	access_plan_t plan;
	access_plan_t held;
	logic         held_valid;
	logic         read_start;
	logic         write_start;
	logic         read_finish;
	logic         write_finish;

	// either engine ends the held request
	assign done    = read_finish | write_finish;
	assign allowin = !held_valid || done;

	assign read_start  = held_valid && !is_store_kind(held.kind);
	assign write_start = held_valid && is_store_kind(held.kind);

	assign wb_valid = read_finish;
	assign wb_rd    = held.rd;

	access_planner u_access_planner (
		.req  (req),
		.plan (plan)
	);

	request_stage u_request_stage (
		.clock      (clock),
		.reset      (reset),
		.plan_in    (plan),
		.in_valid   (req_valid),
		.done       (done),
		.allowin    (allowin),
		.held       (held),
		.held_valid (held_valid)
	);

	read_engine u_read_engine (
		.clock     (clock),
		.reset     (reset),
		.held      (held),
		.start     (read_start),
		.arvalid   (arvalid),
		.araddr    (araddr),
		.arsize    (arsize),
		.arready   (arready),
		.rready    (rready),
		.rvalid    (rvalid),
		.rdata     (rdata),
		.finish    (read_finish),
		.load_data (wb_data)
	);

	write_engine u_write_engine (
		.clock   (clock),
		.reset   (reset),
		.held    (held),
		.start   (write_start),
		.awvalid (awvalid),
		.awaddr  (awaddr),
		.awsize  (awsize),
		.awready (awready),
		.wvalid  (wvalid),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wready  (wready),
		.bready  (bready),
		.bvalid  (bvalid),
		.finish  (write_finish)
	);

endmodule

/* hw/request_stage.sv */
`timescale 1ns/1ns
module request_stage (
	input  logic                  clock,
	input  logic                  reset,
	input  lsu_pkg::access_plan_t plan_in,
	input  logic                  in_valid,
	input  logic                  done,
	input  logic                  allowin,
	output lsu_pkg::access_plan_t held,
	output logic                  held_valid
);
	import lsu_pkg::*;

	// held valid follows the input whenever the stage can take one
	always_ff @(posedge clock) begin
		if (reset) begin
			held_valid <= 1'b0;
		end else if (allowin) begin
			held_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (allowin && in_valid) begin
			held <= plan_in;
		end
	end

	// an engine may only finish a request that is held
	assert property (@(posedge clock) disable iff (reset)
		done |-> held_valid)
		else $error("done without a held request");

endmodule

/* sim.f */
common/lsu_pkg.sv
hw/access_planner.sv
hw/request_stage.sv
bus_master/read_engine.sv
bus_master/write_engine.sv
hw/lsu_top.sv
test/bus_memory_model.sv
test/tb_lsu.sv

/* test/bus_memory_model.sv */
`timescale 1ns/1ns
module bus_memory_model (
	input  logic                clock,
	input  logic                reset,
	input  logic                arvalid,
	input  lsu_pkg::addr_t      araddr,
	input  lsu_pkg::xfer_size_t arsize,
	output logic                arready,
	input  logic                rready,
	output logic                rvalid,
	output lsu_pkg::bus_data_t  rdata,
	input  logic                awvalid,
	input  lsu_pkg::addr_t      awaddr,
	input  lsu_pkg::xfer_size_t awsize,
	output logic                awready,
	input  logic                wvalid,
	input  lsu_pkg::bus_data_t  wdata,
	input  lsu_pkg::strb_t      wstrb,
	output logic                wready,
	input  logic                bready,
	output logic                bvalid,
	output int                  ar_count,
	output int                  b_count,
	output lsu_pkg::addr_t      last_araddr,
	output lsu_pkg::xfer_size_t last_arsize,
	output lsu_pkg::addr_t      last_awaddr,
	output lsu_pkg::xfer_size_t last_awsize
);
	import lsu_pkg::*;

	logic [7:0] mem [0:255];
	integer     seed;
	logic [1:0] ar_wait;
	logic [1:0] r_wait;
	logic [1:0] aw_wait;
	logic [1:0] w_wait;
	logic [1:0] b_wait;
	logic       rd_pend;
	logic       aw_got;
	logic       w_got;
	logic [7:0] rd_addr;
	logic [7:0] wr_addr;
	bus_data_t  wr_data;
	strb_t      wr_strb;

	initial seed = 20909;

	// 0 to 3 cycles
	function logic [1:0] pick_delay();
		pick_delay = $random(seed);
	endfunction

	// ------------------------------------------------------------
	// handshakes seen on the rising edge
	// ------------------------------------------------------------
	always @(posedge clock) begin
		if (reset) begin
			ar_count <= 0;
			b_count  <= 0;
			rd_pend  <= 1'b0;
			aw_got   <= 1'b0;
			w_got    <= 1'b0;
			ar_wait  <= '0;
			r_wait   <= '0;
			aw_wait  <= '0;
			w_wait   <= '0;
			b_wait   <= '0;
		end else begin
			if (arvalid && arready) begin
				rd_pend     <= 1'b1;
				rd_addr     <= araddr[7:0];
				last_araddr <= araddr;
				last_arsize <= arsize;
				ar_count    <= ar_count + 1;
				ar_wait     <= pick_delay();
				r_wait      <= pick_delay();
			end else if (ar_wait != 0) begin
				ar_wait <= ar_wait - 1;
			end
			if (rvalid && rready) begin
				rd_pend <= 1'b0;
			end else if (rd_pend && r_wait != 0) begin
				r_wait <= r_wait - 1;
			end
			if (awvalid && awready) begin
				aw_got      <= 1'b1;
				wr_addr     <= awaddr[7:0];
				last_awaddr <= awaddr;
				last_awsize <= awsize;
				aw_wait     <= pick_delay();
				b_wait      <= pick_delay();
			end else if (aw_wait != 0) begin
				aw_wait <= aw_wait - 1;
			end
			if (wvalid && wready) begin
				w_got   <= 1'b1;
				wr_data <= wdata;
				wr_strb <= wstrb;
				w_wait  <= pick_delay();
			end else if (w_wait != 0) begin
				w_wait <= w_wait - 1;
			end
			// write lands in memory with the B handshake
			if (bvalid && bready) begin
				for (int i = 0; i < 8; i++) begin
					if (wr_strb[i]) begin
						mem[{wr_addr[7:3], 3'(i)}] <= wr_data[8*i +: 8];
					end
				end
				aw_got  <= 1'b0;
				w_got   <= 1'b0;
				b_count <= b_count + 1;
			end else if (aw_got && w_got && b_wait != 0) begin
				b_wait <= b_wait - 1;
			end
		end
	end

	// outputs change on the falling edge
	always @(negedge clock) begin
		if (reset) begin
			arready = 1'b0;
			awready = 1'b0;
			wready  = 1'b0;
			rvalid  = 1'b0;
			bvalid  = 1'b0;
			rdata   = '0;
		end else begin
			arready = ar_wait == 0;
			awready = aw_wait == 0;
			wready  = w_wait == 0;
			rvalid  = rd_pend && r_wait == 0;
			bvalid  = aw_got && w_got && b_wait == 0;
			for (int i = 0; i < 8; i++) begin
				rdata[8*i +: 8] = mem[{rd_addr[7:3], 3'(i)}];
			end
		end
	end

endmodule

/* test/tb_lsu.sv */
`timescale 1ns/1ns
module tb_lsu;
	import lsu_pkg::*;

	localparam int TIMEOUT = 200;

	logic       clock;
	logic       reset;
	logic       req_valid;
	lsu_req_t   req;
	logic       allowin;
	logic       done;
	logic       wb_valid;
	reg_idx_t   wb_rd;
	word_t      wb_data;
	logic       arvalid;
	addr_t      araddr;
	xfer_size_t arsize;
	logic       arready;
	logic       rready;
	logic       rvalid;
	bus_data_t  rdata;
	logic       awvalid;
	addr_t      awaddr;
	xfer_size_t awsize;
	logic       awready;
	logic       wvalid;
	bus_data_t  wdata;
	strb_t      wstrb;
	logic       wready;
	logic       bready;
	logic       bvalid;
	int         ar_count;
	int         b_count;
	addr_t      last_araddr;
	xfer_size_t last_arsize;
	addr_t      last_awaddr;
	xfer_size_t last_awsize;
	integer     seed;
	logic [7:0] ref_mem [0:255];

	lsu_top u_lsu_top (
		.clock(clock), .reset(reset), .req_valid(req_valid), .req(req),
		.allowin(allowin), .done(done), .wb_valid(wb_valid), .wb_rd(wb_rd),
		.wb_data(wb_data), .arvalid(arvalid), .araddr(araddr), .arsize(arsize),
		.arready(arready), .rready(rready), .rvalid(rvalid), .rdata(rdata),
		.awvalid(awvalid), .awaddr(awaddr), .awsize(awsize), .awready(awready),
		.wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
		.bready(bready), .bvalid(bvalid)
	);

	bus_memory_model u_bus_memory_model (
		.clock(clock), .reset(reset), .arvalid(arvalid), .araddr(araddr),
		.arsize(arsize), .arready(arready), .rready(rready), .rvalid(rvalid),
		.rdata(rdata), .awvalid(awvalid), .awaddr(awaddr), .awsize(awsize),
		.awready(awready), .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb),
		.wready(wready), .bready(bready), .bvalid(bvalid), .ar_count(ar_count),
		.b_count(b_count), .last_araddr(last_araddr), .last_arsize(last_arsize),
		.last_awaddr(last_awaddr), .last_awsize(last_awsize)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic check(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s actual %h expected %h", name, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timed out waiting for %s", what);
		$display("STATUS: FAIL");
		$fatal(1, "timeout");
	endtask

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	function automatic logic [7:0] fill_byte(input int a);
		return 8'(a * 37 + (a >> 3) * 11) ^ 8'h5c;
	endfunction

	function automatic bit is_load(input access_kind_t kind);
		return kind inside {LD_B, LD_H, LD_W, LD_BU, LD_HU};
	endfunction

	function automatic int access_bytes(input access_kind_t kind);
		if (kind inside {LD_B, LD_BU, ST_B}) return 1;
		if (kind inside {LD_H, LD_HU, ST_H}) return 2;
		return 4;
	endfunction

	function automatic logic [2:0] size_code(input access_kind_t kind);
		return access_bytes(kind) == 1 ? 3'd0 : (access_bytes(kind) == 2 ? 3'd1 : 3'd2);
	endfunction

	// crosses the 8-byte beat
	function automatic bit crosses_beat(input access_kind_t kind, input addr_t addr);
		return int'(addr[2:0]) + access_bytes(kind) > 8;
	endfunction

	function automatic word_t model_load(input access_kind_t kind, input addr_t addr);
		word_t raw;
		for (int i = 0; i < 4; i++) begin
			raw[8*i +: 8] = ref_mem[8'(addr[7:0] + i)];
		end
		case (kind)
			LD_B:    return {{24{raw[7]}}, raw[7:0]};
			LD_BU:   return {24'b0, raw[7:0]};
			LD_H:    return {{16{raw[15]}}, raw[15:0]};
			LD_HU:   return {16'b0, raw[15:0]};
			default: return raw;
		endcase
	endfunction

	// ------------------------------------------------------------
	// request driving and checking
	// ------------------------------------------------------------
	task automatic wait_allowin();
		int n;
		n = 0;
		while (!allowin) begin
			@(negedge clock);
			n++;
			if (n > TIMEOUT) timeout_fail("allowin");
		end
	endtask

	task automatic drive_request(input access_kind_t kind, input addr_t addr,
			input word_t data, input reg_idx_t rd);
		wait_allowin();
		req_valid = 1'b1;
		req = '{kind: kind, addr: addr, wdata: data, rd: rd};
	endtask

	task automatic finish_request(input access_kind_t kind, input addr_t addr,
			input word_t data, input reg_idx_t rd, input int ar0, input int b0);
		int    n;
		int    beats;
		addr_t last_addr;
		n = 0;
		while (!done) begin
			check("wb_valid", wb_valid, 0);
			@(negedge clock);
			n++;
			if (n > TIMEOUT) timeout_fail("done");
		end
		beats = crosses_beat(kind, addr) ? 2 : 1;
		last_addr = crosses_beat(kind, addr) ? {addr[31:3], 3'b000} + 32'd8 : addr;
		check("wb_valid", wb_valid, is_load(kind));
		if (is_load(kind)) begin
			check("wb_rd", wb_rd, rd);
			check("wb_data", wb_data, model_load(kind, addr));
			check("ar handshakes", ar_count - ar0, beats);
			check("b handshakes", b_count - b0, 0);
			check("araddr", last_araddr, last_addr);
			check("arsize", last_arsize, size_code(kind));
		end else begin
			for (int i = 0; i < access_bytes(kind); i++) begin
				ref_mem[8'(addr[7:0] + i)] = data[8*i +: 8];
			end
			check("b handshakes", b_count - b0, beats);
			check("ar handshakes", ar_count - ar0, 0);
			check("awaddr", last_awaddr, last_addr);
			check("awsize", last_awsize, size_code(kind));
			for (int i = 0; i < 256; i++) begin
				check($sformatf("mem[%0d]", i), u_bus_memory_model.mem[i], ref_mem[i]);
			end
		end
	endtask

	// mode 0 loads, 1 stores, 2 either
	task automatic random_request(input int mode, output access_kind_t kind,
			output addr_t addr, output word_t data, output reg_idx_t rd);
		int unsigned raw;
		raw = $unsigned($random(seed));
		if (mode == 0) kind = access_kind_t'(raw % 5);
		else if (mode == 1) kind = access_kind_t'(5 + raw % 3);
		else kind = access_kind_t'(raw % 8);
		addr = $random(seed);
		data = $random(seed);
		rd = $random(seed);
	endtask

	task automatic run_one(input int mode);
		access_kind_t kind;
		addr_t        addr;
		word_t        data;
		reg_idx_t     rd;
		int           ar0;
		int           b0;
		random_request(mode, kind, addr, data, rd);
		drive_request(kind, addr, data, rd);
		ar0 = ar_count;
		b0 = b_count;
		@(negedge clock);
		req_valid = 1'b0;
		finish_request(kind, addr, data, rd, ar0, b0);
	endtask

	// second request waits while allowin is low
	task automatic run_pair();
		access_kind_t kind_a;
		access_kind_t kind_b;
		addr_t        addr_a;
		addr_t        addr_b;
		word_t        data_a;
		word_t        data_b;
		reg_idx_t     rd_a;
		reg_idx_t     rd_b;
		int           ar0;
		int           b0;
		random_request(2, kind_a, addr_a, data_a, rd_a);
		random_request(2, kind_b, addr_b, data_b, rd_b);
		drive_request(kind_a, addr_a, data_a, rd_a);
		ar0 = ar_count;
		b0 = b_count;
		@(negedge clock);
		check("allowin", allowin, 0);
		req = '{kind: kind_b, addr: addr_b, wdata: data_b, rd: rd_b};
		finish_request(kind_a, addr_a, data_a, rd_a, ar0, b0);
		ar0 = ar_count;
		b0 = b_count;
		@(negedge clock);
		req_valid = 1'b0;
		finish_request(kind_b, addr_b, data_b, rd_b, ar0, b0);
	endtask

	initial begin
		seed = 20909;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		for (int i = 0; i < 256; i++) begin
			ref_mem[i] = fill_byte(i);
			u_bus_memory_model.mem[i] = fill_byte(i);
		end
		repeat (3) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		check("arvalid", arvalid, 0);
		check("awvalid", awvalid, 0);
		check("wvalid", wvalid, 0);
		check("rready", rready, 0);
		check("bready", bready, 0);
		check("done", done, 0);
		check("allowin", allowin, 1);

		repeat (60) run_one(0);
		repeat (60) run_one(1);
		// back to back, each new request enters on the done cycle
		repeat (150) run_one(2);
		repeat (20) run_pair();

		$display("STATUS: PASS");
		$finish;
	end

endmodule
